// File: design/remc_pkg.sv
package remc_pkg;

    localparam int replica_num = 8;
    localparam int rand_lanes  = replica_num / 2;     // one random word per even position

    typedef logic signed [15:0] energy_t;
    typedef logic [3:0]         label_t;
    typedef logic [31:0]        rand_word_t;
    typedef logic [15:0]        accept_cnt_t;
    typedef logic [7:0]         sweep_cnt_t;
    typedef logic [$clog2(replica_num)-1:0] slot_idx_t;
    typedef logic [7:0]         axil_addr_t;
    typedef logic [31:0]        axil_data_t;

    typedef struct packed {
        label_t  label;
        energy_t energy;
    } replica_slot_t;

    typedef replica_slot_t [replica_num-1:0] slot_array_t;
    typedef rand_word_t [rand_lanes-1:0]     rand_bank_t;

    typedef enum logic [0:0] {OR1, OR2} opt_command_t;
    typedef enum logic [1:0] {NOP, SELF, PREV, FOLW} exchange_command_t;
    typedef enum logic [2:0] {IDLE, TEST, EXCH, SHIFT, DONE} ctrl_state_t;

    // action = (e_hi - e_lo) * dbeta_q >>> action_shift
    localparam int dbeta_q      = 40;
    localparam int action_shift = 8;

    // round(exp(-k/8) * 65536), entry 0 clipped
    localparam logic [15:0] exp_lut [64] = '{
        16'd65535, 16'd57835, 16'd51039, 16'd45042, 16'd39750, 16'd35079, 16'd30957, 16'd27319,
        16'd24109, 16'd21276, 16'd18776, 16'd16570, 16'd14623, 16'd12905, 16'd11388, 16'd10050,
        16'd8869,  16'd7827,  16'd6907,  16'd6096,  16'd5380,  16'd4747,  16'd4190,  16'd3697,
        16'd3263,  16'd2879,  16'd2541,  16'd2243,  16'd1979,  16'd1746,  16'd1541,  16'd1360,
        16'd1200,  16'd1059,  16'd935,   16'd825,   16'd728,   16'd642,   16'd567,   16'd500,
        16'd442,   16'd390,   16'd344,   16'd303,   16'd268,   16'd236,   16'd209,   16'd184,
        16'd162,   16'd143,   16'd127,   16'd112,   16'd99,    16'd87,    16'd77,    16'd68,
        16'd60,    16'd53,    16'd47,    16'd41,    16'd36,    16'd32,    16'd28,    16'd25
    };

    // xorshift lane seeding
    localparam rand_word_t seed_spread  = 32'h9e37_79b9;
    localparam rand_word_t seed_default = 32'h2545_f491;

    // register map, byte offsets
    localparam axil_addr_t reg_ctrl      = 8'h00;
    localparam axil_addr_t reg_status    = 8'h04;
    localparam axil_addr_t reg_seed      = 8'h08;
    localparam axil_addr_t reg_accept    = 8'h0C;
    localparam axil_addr_t reg_slot_base = 8'h40;
    localparam logic [1:0] resp_okay     = 2'b00;

endpackage

// File: design/replica_exchange_test.sv
`timescale 1ns/10ps

module replica_exchange_test
    import remc_pkg::*;
#(
    parameter int id = 0
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              replica_run,
    input  logic              exchange_run,
    input  opt_command_t      opt_command,
    input  rand_word_t        r_exchange,
    input  energy_t           prev_data,
    input  energy_t           self_data,
    input  energy_t           folw_data,
    input  logic              prev_exchange,     // test bit of the lower neighbour
    input  logic              folw_exchange,     // test bit of the upper neighbour
    output logic              out_exchange,
    output exchange_command_t exchange_cmd
);

    localparam bit is_odd = (id % 2) == 1;

    energy_t            lo_e;
    energy_t            hi_e;
    logic signed [16:0] diff;
    logic signed [31:0] action;
    logic [31:0]        neg_action;
    logic [5:0]         lut_idx;
    logic               accept;
    logic               test_q;

    always_comb begin
        if (opt_command == OR1) begin              // pair with lower neighbour
            lo_e = prev_data;
            hi_e = self_data;
        end else begin
            lo_e = self_data;
            hi_e = folw_data;
        end
        diff       = {hi_e[15], hi_e} - {lo_e[15], lo_e};
        action     = (32'(diff) * dbeta_q) >>> action_shift;
        neg_action = -action;
        lut_idx    = (neg_action > 32'd63) ? 6'd63 : neg_action[5:0];
        accept     = (action >= 0) || (r_exchange[31:16] < exp_lut[lut_idx]);
    end

    assign out_exchange = test_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            test_q       <= 1'b0;
            exchange_cmd <= NOP;
        end else begin
            if (replica_run) begin
                test_q <= accept && !is_odd;         // only even cells decide
            end
            if (!exchange_run) begin
                exchange_cmd <= NOP;
            end else if (opt_command == OR1) begin
                if (is_odd) begin
                    exchange_cmd <= (id != replica_num - 1 && folw_exchange) ? FOLW : SELF;
                end else begin
                    exchange_cmd <= (id != 0 && test_q) ? PREV : SELF;
                end
            end else begin
                if (is_odd) begin
                    exchange_cmd <= prev_exchange ? PREV : SELF;
                end else begin
                    exchange_cmd <= test_q ? FOLW : SELF;
                end
            end
        end
    end

    a_nop_outside_exch: assert property (
        @(posedge clk) disable iff (!arst_n)
        !exchange_run |=> exchange_cmd == NOP
    );

endmodule

// File: design/xorshift_bank.sv
`timescale 1ns/10ps

module xorshift_bank
    import remc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       seed_load,
    input  rand_word_t seed,
    input  logic       step,
    output rand_bank_t rand_words
);

    function automatic rand_word_t xs32_next(rand_word_t x);
        rand_word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // lane k starts from seed ^ k*spread, a zero state would lock up
    function automatic rand_word_t lane_seed(rand_word_t s, int k);
        rand_word_t v;
        v = s ^ rand_word_t'(32'(k) * seed_spread);
        return (v == '0) ? 32'h1 : v;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < rand_lanes; k++) begin
                rand_words[k] <= lane_seed(seed_default, k);
            end
        end else if (seed_load) begin
            for (int k = 0; k < rand_lanes; k++) begin
                rand_words[k] <= lane_seed(seed, k);
            end
        end else if (step) begin
            for (int k = 0; k < rand_lanes; k++) begin
                rand_words[k] <= xs32_next(rand_words[k]);
            end
        end
    end

    for (genvar k = 0; k < rand_lanes; k++) begin : g_chk
        a_state_nonzero: assert property (
            @(posedge clk) disable iff (!arst_n) rand_words[k] != '0
        );
    end

endmodule

// File: design/replica_chain.sv
`timescale 1ns/10ps

module replica_chain
    import remc_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          slot_we,
    input  slot_idx_t     slot_idx,
    input  replica_slot_t slot_wdata,
    input  logic          replica_run,
    input  logic          exchange_run,
    input  logic          shift,
    input  opt_command_t  opt_command,
    input  rand_bank_t    rand_words,
    output slot_array_t   slots,
    output accept_cnt_t   accept_cnt
);

    exchange_command_t       cmd [replica_num];
    logic [replica_num-1:0]  test_bit;
    slot_array_t             next_slots;
    logic [2:0]              pairs;

    for (genvar i = 0; i < replica_num; i++) begin : g_pos
        energy_t prev_e;
        energy_t folw_e;
        logic    prev_x;
        logic    folw_x;

        if (i == 0) begin : g_first              // no lower neighbour
            assign prev_e        = slots[i].energy;
            assign prev_x        = 1'b0;
            assign next_slots[i] = (cmd[i] == FOLW) ? slots[i+1] : slots[i];
        end else if (i == replica_num - 1) begin : g_last
            assign prev_e        = slots[i-1].energy;
            assign prev_x        = test_bit[i-1];
            assign next_slots[i] = (cmd[i] == PREV) ? slots[i-1] : slots[i];
        end else begin : g_mid
            assign prev_e        = slots[i-1].energy;
            assign prev_x        = test_bit[i-1];
            assign next_slots[i] = (cmd[i] == PREV) ? slots[i-1] :
                                   (cmd[i] == FOLW) ? slots[i+1] : slots[i];
        end

        if (i == replica_num - 1) begin : g_top
            assign folw_e = slots[i].energy;
            assign folw_x = 1'b0;
        end else begin : g_below
            assign folw_e = slots[i+1].energy;
            assign folw_x = test_bit[i+1];
        end

        replica_exchange_test #(.id(i)) u_test (
            .clk           (clk),
            .arst_n        (arst_n),
            .replica_run   (replica_run),
            .exchange_run  (exchange_run),
            .opt_command   (opt_command),
            .r_exchange    (rand_words[i/2]),       // lane shared by the pair
            .prev_data     (prev_e),
            .self_data     (slots[i].energy),
            .folw_data     (folw_e),
            .prev_exchange (prev_x),
            .folw_exchange (folw_x),
            .out_exchange  (test_bit[i]),
            .exchange_cmd  (cmd[i])
        );

        if (i > 0) begin : g_match
            a_prev_folw: assert property (
                @(posedge clk) disable iff (!arst_n)
                cmd[i] == PREV |-> cmd[i-1] == FOLW
            );
        end
    end

    // each accepted pair has exactly one even member
    always_comb begin
        pairs = '0;
        for (int i = 0; i < replica_num; i += 2) begin
            if (cmd[i] == PREV || cmd[i] == FOLW) begin
                pairs = pairs + 3'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slots      <= '0;
            accept_cnt <= '0;
        end else if (shift) begin
            slots      <= next_slots;
            accept_cnt <= accept_cnt + accept_cnt_t'(pairs);
        end else if (slot_we) begin
            slots[slot_idx] <= slot_wdata;      // host write
        end
    end

endmodule

// File: design/sweep_ctrl.sv
`timescale 1ns/10ps

module sweep_ctrl
    import remc_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         start,
    input  sweep_cnt_t   sweeps,
    output logic         replica_run,
    output logic         exchange_run,
    output logic         shift,
    output opt_command_t opt_command,
    output logic         busy,
    output logic         done
);

    ctrl_state_t state;
    sweep_cnt_t  remain;                        // sweeps still to finish

    assign replica_run  = (state == TEST);
    assign exchange_run = (state == EXCH);
    assign shift        = (state == SHIFT);
    assign busy         = replica_run || exchange_run || shift;
    assign done         = (state == DONE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            opt_command <= OR1;
            remain      <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        opt_command <= OR1;
                        remain      <= sweeps;
                        state       <= (sweeps == '0) ? DONE : TEST;
                    end
                end
                TEST:  state <= EXCH;
                EXCH:  state <= SHIFT;
                SHIFT: begin
                    if (opt_command == OR1) begin
                        opt_command <= OR2;     // second half of the sweep
                        state       <= TEST;
                    end else begin
                        opt_command <= OR1;
                        remain      <= remain - 8'd1;
                        state       <= (remain == 8'd1) ? DONE : TEST;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/axil_regs.sv
`timescale 1ns/10ps

module axil_regs
    import remc_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  axil_addr_t    awaddr,
    input  logic          awvalid,
    output logic          awready,
    input  axil_data_t    wdata,
    input  logic [3:0]    wstrb,
    input  logic          wvalid,
    output logic          wready,
    output logic [1:0]    bresp,
    output logic          bvalid,
    input  logic          bready,
    input  axil_addr_t    araddr,
    input  logic          arvalid,
    output logic          arready,
    output axil_data_t    rdata,
    output logic [1:0]    rresp,
    output logic          rvalid,
    input  logic          rready,
    output logic          start,
    output sweep_cnt_t    sweeps,
    output logic          seed_load,
    output rand_word_t    seed,
    output logic          slot_we,
    output slot_idx_t     slot_idx,
    output replica_slot_t slot_wdata,
    input  logic          busy,
    input  logic          done,
    input  slot_array_t   slots,
    input  accept_cnt_t   accept_cnt
);

    logic       wr_fire;
    logic       rd_fire;
    axil_addr_t wr_word;
    axil_addr_t rd_word;
    axil_data_t wmask;
    axil_data_t slot_merged;
    axil_data_t rd_data;
    logic       wr_ctrl;
    logic       wr_seed;

    // address and data are taken together, only with no response pending
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = !rvalid;
    assign rd_fire = arvalid && !rvalid;
    assign bresp   = resp_okay;
    assign rresp   = resp_okay;

    assign wr_word = {awaddr[7:2], 2'b00};
    assign rd_word = {araddr[7:2], 2'b00};
    assign wmask   = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

    assign wr_ctrl  = wr_fire && (wr_word == reg_ctrl);
    assign wr_seed  = wr_fire && (wr_word == reg_seed) && !busy;
    assign start    = wr_ctrl && wstrb[0] && wdata[0];     // pulse, not stored
    assign slot_we  = wr_fire && (awaddr[7:5] == reg_slot_base[7:5]) && !busy;
    assign slot_idx = awaddr[4:2];

    // byte-lane merge with the current slot contents
    assign slot_merged = ({12'h0, slots[slot_idx]} & ~wmask) | (wdata & wmask);
    assign slot_wdata  = replica_slot_t'(slot_merged[19:0]);

    always_comb begin
        case (rd_word)
            reg_ctrl:   rd_data = {16'h0, sweeps, 8'h0};
            reg_status: rd_data = {30'h0, done, busy};
            reg_seed:   rd_data = seed;
            reg_accept: rd_data = {16'h0, accept_cnt};
            default: begin
                if (araddr[7:5] == reg_slot_base[7:5]) begin
                    rd_data = {12'h0, slots[araddr[4:2]]};
                end else begin
                    rd_data = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            sweeps    <= '0;
            seed      <= seed_default;
            seed_load <= 1'b0;
        end else begin
            seed_load <= wr_seed;               // lanes load the new seed next cycle
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_ctrl && wstrb[1]) begin
                sweeps <= wdata[15:8];
            end
            if (wr_seed) begin
                seed <= (seed & ~wmask) | (wdata & wmask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data;
        end
    end

endmodule

// File: design/remc_top.sv
`timescale 1ns/10ps

module remc_top
    import remc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  axil_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axil_data_t wdata,
    input  logic [3:0] wstrb,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output axil_data_t rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready
);

    logic          start;
    logic          seed_load;
    logic          slot_we;
    logic          busy;
    logic          done;
    logic          replica_run;
    logic          exchange_run;
    logic          shift;
    sweep_cnt_t    sweeps;
    rand_word_t    seed;
    slot_idx_t     slot_idx;
    replica_slot_t slot_wdata;
    slot_array_t   slots;
    accept_cnt_t   accept_cnt;
    opt_command_t  opt_command;
    rand_bank_t    rand_words;

    axil_regs u_regs (
        .clk, .arst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .start, .sweeps, .seed_load, .seed,
        .slot_we, .slot_idx, .slot_wdata,
        .busy, .done, .slots, .accept_cnt
    );

    sweep_ctrl u_ctrl (
        .clk, .arst_n, .start, .sweeps,
        .replica_run, .exchange_run, .shift, .opt_command,
        .busy, .done
    );

    xorshift_bank u_rng (
        .clk, .arst_n, .seed_load, .seed,
        .step       (replica_run),          // advance after each test cycle
        .rand_words
    );

    replica_chain u_chain (
        .clk, .arst_n, .slot_we, .slot_idx, .slot_wdata,
        .replica_run, .exchange_run, .shift, .opt_command,
        .rand_words, .slots, .accept_cnt
    );

endmodule

// File: dv/remc_tb.sv
`timescale 1ns/10ps

module remc_tb
    import remc_pkg::*;
;

    typedef struct packed {
        slot_array_t init;
        rand_word_t  seed;
        sweep_cnt_t  sweeps;
        logic        mono;                      // energies rise with position
    } case_row_t;

    localparam int num_cases = 5;

    logic       clk;
    logic       arst_n;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    case_row_t   cases [num_cases];
    slot_array_t m_slots;                       // reference model state
    rand_bank_t  m_lanes;
    accept_cnt_t m_count;
    integer      rng_seed;
    int          value_errors;
    int          protocol_errors;
    int          cycles;
    int          limit;

    remc_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("Run stopped: no finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_slot(input replica_slot_t got, input replica_slot_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got label %0d energy %0d, expected label %0d energy %0d",
                     $time, what, got.label, got.energy, exp.label, exp.energy);
        end
    endtask

    task automatic check_count(input accept_cnt_t got, input accept_cnt_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input rand_word_t got, input rand_word_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic rand_word_t next_xorshift(rand_word_t x);
        rand_word_t t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    function automatic rand_word_t spread_seed(rand_word_t s, int k);
        return s ^ (rand_word_t'(k) * 32'h9e37_79b9);
    endfunction

    // Metropolis rule for one pair, lo below hi
    function automatic bit pair_accepts(energy_t lo_e, energy_t hi_e, rand_word_t r);
        int         d;
        int         act;
        logic [5:0] idx;
        d   = int'(hi_e) - int'(lo_e);
        act = (d * 40) >>> 8;
        if (act >= 0) begin
            return 1'b1;
        end
        idx = (-act > 63) ? 6'd63 : 6'(-act);
        return r[31:16] < exp_lut[idx];
    endfunction

    task automatic model_run(input int sweeps);
        replica_slot_t tmp;
        int            even;
        for (int s = 0; s < sweeps; s++) begin
            for (int ph = 0; ph < 2; ph++) begin
                for (int lo = 1 - ph; lo < replica_num - 1; lo += 2) begin
                    even = (lo % 2 == 0) ? lo : lo + 1;
                    if (pair_accepts(m_slots[lo].energy, m_slots[lo+1].energy,
                                     m_lanes[even/2])) begin
                        tmp          = m_slots[lo];
                        m_slots[lo]  = m_slots[lo+1];
                        m_slots[lo+1] = tmp;
                        m_count      = m_count + 16'd1;
                    end
                end
                for (int k = 0; k < rand_lanes; k++) begin
                    m_lanes[k] = next_xorshift(m_lanes[k]);   // every lane steps each phase
                end
            end
        end
    endtask

    // all bus tasks start and end 2 ns after a rising edge
    task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
        int         hold;
        bit         taken;
        logic [1:0] resp;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = awready && wready;
            @(posedge clk);
            #2;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        hold    = $random(rng_seed) & 3;
        repeat (hold) begin
            @(negedge clk);
            if (!bvalid) begin
                protocol_errors++;
                $display("Write response to %h missing while bready was low", addr);
            end
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = bvalid;
            resp  = bresp;
            @(posedge clk);
            #2;
        end
        bready = 1'b0;
        if (bvalid) begin
            protocol_errors++;
            $display("Write to %h produced a second response", addr);
        end
        check_word(rand_word_t'(resp), 32'h0, "write response code");
    endtask

    task automatic axi_read(input axil_addr_t addr, output axil_data_t data);
        int         hold;
        bit         taken;
        logic [1:0] resp;
        axil_data_t first;
        araddr  = addr;
        arvalid = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = arready;
            @(posedge clk);
            #2;
        end
        arvalid = 1'b0;
        hold    = $random(rng_seed) & 3;
        first   = rdata;
        repeat (hold) begin
            @(negedge clk);
            if (!rvalid || rdata !== first) begin
                protocol_errors++;
                $display("Read data from %h lost or changed while rready was low", addr);
            end
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rvalid;
            data  = rdata;
            resp  = rresp;
            @(posedge clk);
            #2;
        end
        rready = 1'b0;
        if (rvalid) begin
            protocol_errors++;
            $display("Read from %h produced a second response", addr);
        end
        check_word(rand_word_t'(resp), 32'h0, "read response code");
    endtask

    task automatic wait_done();
        axil_data_t st;
        st = '0;
        while (!st[1]) begin
            axi_read(reg_status, st);
        end
    endtask

    task automatic fill_row(input int r, input int spread, input rand_word_t seed,
                            input sweep_cnt_t sweeps, input logic mono);
        cases[r].seed   = seed;
        cases[r].sweeps = sweeps;
        cases[r].mono   = mono;
        for (int i = 0; i < replica_num; i++) begin
            cases[r].init[i].label = label_t'((i * 5 + r) % 16);   // distinct per row
            if (mono) begin
                cases[r].init[i].energy = energy_t'(100 * i - 350);
            end else begin
                cases[r].init[i].energy = energy_t'($random(rng_seed) % spread);
            end
        end
    endtask

    task automatic run_row(input int r);
        axil_data_t  d;
        accept_cnt_t acc_before;
        case_row_t   row;
        row = cases[r];
        for (int i = 0; i < replica_num; i++) begin
            axi_write(axil_addr_t'(reg_slot_base + 4 * i), {12'h0, row.init[i]});
        end
        axi_write(reg_seed, row.seed);
        m_slots = row.init;
        for (int k = 0; k < rand_lanes; k++) begin
            m_lanes[k] = spread_seed(row.seed, k);
        end
        for (int i = 0; i < replica_num; i++) begin
            axi_read(axil_addr_t'(reg_slot_base + 4 * i), d);
            check_slot(replica_slot_t'(d[19:0]), row.init[i],
                       $sformatf("row %0d slot %0d readback", r, i));
        end
        axi_read(reg_seed, d);
        check_word(d, row.seed, $sformatf("row %0d seed readback", r));
        axi_read(reg_accept, d);
        acc_before = accept_cnt_t'(d[15:0]);
        check_count(acc_before, m_count, $sformatf("row %0d accept count before run", r));

        model_run(int'(row.sweeps));
        axi_write(reg_ctrl, {16'h0, row.sweeps, 8'h00});   // start samples the stored count
        axi_write(reg_ctrl, {16'h0, row.sweeps, 8'h01});
        axi_read(reg_status, d);
        if (row.sweeps == 8'd0) begin
            check_word(d, 32'h2, $sformatf("row %0d status after empty run", r));
        end else if (row.sweeps >= 8'd3) begin
            check_word(d, 32'h1, $sformatf("row %0d status while running", r));
        end
        if (row.sweeps >= 8'd10) begin
            axi_write(reg_slot_base + 8'd12, 32'h000f_7fff);  // dropped while the engine is busy
        end
        wait_done();

        for (int i = 0; i < replica_num; i++) begin
            axi_read(axil_addr_t'(reg_slot_base + 4 * i), d);
            check_slot(replica_slot_t'(d[19:0]), m_slots[i],
                       $sformatf("row %0d final slot %0d", r, i));
        end
        axi_read(reg_accept, d);
        check_count(accept_cnt_t'(d[15:0]), m_count, $sformatf("row %0d accept count", r));
        if (row.mono) begin
            check_count(accept_cnt_t'(d[15:0]) - acc_before, 16'd7,
                        $sformatf("row %0d swaps in one sweep", r));
        end
    endtask

    initial begin
        axil_data_t d;
        int         total;
        arst_n          = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wstrb           = 4'h0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        cycles          = 0;
        m_count         = '0;
        rng_seed        = 32'h052b_4bfd;

        // empty run first, done is still low from reset
        fill_row(0, 40, 32'h0000_00a5, 8'd0, 1'b0);
        fill_row(1, 0, 32'h1234_5678, 8'd1, 1'b1);
        fill_row(2, 40, 32'h1f2e_3d4c, 8'd3, 1'b0);
        fill_row(3, 2000, 32'h8000_0001, 8'd10, 1'b0);
        fill_row(4, 200, 32'h7c3a_9e15, 8'd25, 1'b0);
        total = 0;
        for (int r = 0; r < num_cases; r++) begin
            total += int'(cases[r].sweeps);
        end
        limit = 200 * total + 2000;

        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #2;

        axi_read(reg_status, d);
        check_word(d, 32'h0, "status after reset");
        axi_read(reg_accept, d);
        check_count(accept_cnt_t'(d[15:0]), 16'd0, "accept count after reset");
        for (int i = 0; i < replica_num; i++) begin
            axi_read(axil_addr_t'(reg_slot_base + 4 * i), d);
            check_slot(replica_slot_t'(d[19:0]), '0, $sformatf("slot %0d after reset", i));
        end

        for (int r = 0; r < num_cases; r++) begin
            run_row(r);
        end

        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: remc.f
design/remc_pkg.sv
design/replica_exchange_test.sv
design/xorshift_bank.sv
design/replica_chain.sv
design/sweep_ctrl.sv
design/axil_regs.sv
design/remc_top.sv
dv/remc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f remc.f --top-module remc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vremc_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
